/* sim.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_lookup.sv
hdl/dcache_data.sv
hdl/fsab_request.sv
hdl/fill_tracker.sv
hdl/dcache_top.sv
test/clock_gen.sv
test/fsab_mem_model.sv
test/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build the cache testbench with Verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module dcache_tb -Mdir obj_dir -o dcache_sim

./obj_dir/dcache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
grep -q "PASS: all tests" sim.log

/* test/dcache_tb.sv */
// ====================
// data cache testbench, runs a table of core accesses against the memory model
// ====================
`timescale 1ns/1ps

module dcache_tb;
	import dcache_pkg::*;

	localparam int WAIT_LIMIT   = 200;
	localparam int STALL_CYCLES = 6;
	localparam int ROWS         = 23;

	typedef enum logic [1:0] {EXP_NONE, EXP_MEM, EXP_DATA} exp_src_e;
	typedef enum logic [1:0] {CR_FREE, CR_HOLD, CR_STALL} credit_mode_e;

	typedef struct packed {
		logic         wr;
		logic [31:0]  addr;
		word_t        data;
		exp_src_e     exp_src;
		logic         reads; // expected bus reads for the row
		credit_mode_e cr;
	} row_t;

	row_t        stim [ROWS];
	logic        clk;
	logic        arst_n;
	logic [31:0] addr;
	logic        rd_req;
	logic        wr_req;
	word_t       wr_data;
	logic        rw_wait;
	word_t       rd_data;
	fsab_req_t   fsab_req;
	logic        fsab_credit;
	fsab_rsp_t   fsab_rsp;
	logic        hold;
	int unsigned read_count;
	int          err_count;

	clock_gen i_clock_gen (.clk, .arst_n);

	fsab_mem_model i_mem (
		.clk, .arst_n, .req (fsab_req), .hold,
		.credit (fsab_credit), .rsp (fsab_rsp), .read_count
	);

	dcache_top i_dcache_top (
		.clk, .arst_n, .addr, .rd_req, .wr_req, .wr_data, .rw_wait, .rd_data,
		.fsab_req, .fsab_credit, .fsab_rsp
	);

	// ====================
	// helpers
	// ====================
	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1, "run aborted");
	endtask

	function automatic word_t model_word(input logic [31:0] a);
		logic [63:0] w;
		w = i_mem.mem[a[11:3]];
		return a[2] ? w[63:32] : w[31:0];
	endfunction

	// sampled on the falling edge where the combinational outputs are settled
	task automatic wait_ready(input int r);
		int n;
		n = 0;
		@(negedge clk);
		while (rw_wait) begin
			if (n == WAIT_LIMIT) begin
				abort_run($sformatf("timed out waiting for rw_wait low on row %0d", r));
			end else begin
				n++;
				@(negedge clk);
			end
		end
	endtask

	task automatic load_table();
		stim[0]  = '{1'b0, 32'h000, 32'h0, EXP_MEM, 1'b1, CR_FREE};
		stim[1]  = '{1'b0, 32'h104, 32'h0, EXP_MEM, 1'b1, CR_FREE};
		stim[2]  = '{1'b0, 32'h008, 32'h0, EXP_MEM, 1'b0, CR_FREE}; // same line, hit
		stim[3]  = '{1'b0, 32'h104, 32'h0, EXP_MEM, 1'b0, CR_FREE};
		stim[4]  = '{1'b1, 32'h010, 32'hcafe0001, EXP_NONE, 1'b0, CR_FREE};
		stim[5]  = '{1'b0, 32'h010, 32'hcafe0001, EXP_DATA, 1'b0, CR_FREE};
		stim[6]  = '{1'b1, 32'h81c, 32'h5a5a1234, EXP_NONE, 1'b0, CR_FREE}; // no allocate
		stim[7]  = '{1'b0, 32'h81c, 32'h5a5a1234, EXP_DATA, 1'b1, CR_FREE};
		stim[8]  = '{1'b0, 32'h040, 32'h0, EXP_MEM, 1'b1, CR_FREE}; // index 1 ping-pong
		stim[9]  = '{1'b0, 32'h440, 32'h0, EXP_MEM, 1'b1, CR_FREE};
		stim[10] = '{1'b0, 32'h044, 32'h0, EXP_MEM, 1'b1, CR_FREE};
		stim[11] = '{1'b0, 32'h444, 32'h0, EXP_MEM, 1'b1, CR_FREE};
		// eight writes drain the credits while returns are held
		for (int k = 0; k < 8; k++) begin
			stim[12+k] = '{1'b1, 32'h300 + 32'(8*k), 32'h10000000 + 32'(k), EXP_NONE,
				1'b0, CR_HOLD};
		end
		stim[20] = '{1'b1, 32'h33c, 32'hdeadbeef, EXP_NONE, 1'b0, CR_STALL};
		stim[21] = '{1'b0, 32'h33c, 32'hdeadbeef, EXP_DATA, 1'b1, CR_FREE};
		stim[22] = '{1'b0, 32'h338, 32'h10000007, EXP_DATA, 1'b0, CR_FREE};
	endtask

	// entered and left 1 ns after a rising edge
	task automatic run_row(input int r);
		row_t        row;
		logic [63:0] old_word;
		int unsigned reads_before;
		word_t       got;
		row          = stim[r];
		old_word     = i_mem.mem[row.addr[11:3]];
		reads_before = read_count;
		hold         = (row.cr != CR_FREE);
		addr         = row.addr;
		wr_data      = row.data;
		rd_req       = !row.wr;
		wr_req       = row.wr;
		if (row.cr == CR_STALL) begin
			repeat (STALL_CYCLES) begin
				@(negedge clk);
				check("rw_wait", 64'(rw_wait), 64'd1);
				check("fsab_req.valid", 64'(fsab_req.valid), 64'd0);
			end
			@(posedge clk);
			#1;
			hold = 1'b0; // let the credits flow back
		end
		wait_ready(r);
		got = rd_data;
		@(posedge clk);
		#1;
		rd_req = 1'b0;
		wr_req = 1'b0;
		check("read_count", 64'(read_count - reads_before), 64'(row.reads));
		if (row.exp_src == EXP_MEM)
			check("rd_data", 64'(got), 64'(model_word(row.addr)));
		else if (row.exp_src == EXP_DATA)
			check("rd_data", 64'(got), 64'(row.data));
		if (row.wr) begin
			check("mem word", i_mem.mem[row.addr[11:3]],
				row.addr[2] ? {row.data, old_word[31:0]} : {old_word[63:32], row.data});
		end
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin : main
		int n;
		err_count = 0;
		addr      = '0;
		rd_req    = 1'b0;
		wr_req    = 1'b0;
		wr_data   = '0;
		hold      = 1'b0;
		load_table();
		n = 0;
		while (!arst_n) begin
			if (n == WAIT_LIMIT) begin
				abort_run("reset never released");
			end else begin
				n++;
				@(posedge clk);
			end
		end
		repeat (3) begin
			@(negedge clk);
			check("fsab_req.valid", 64'(fsab_req.valid), 64'd0); // idle bus after reset
		end
		@(posedge clk);
		#1;
		for (int r = 0; r < ROWS; r++)
			run_row(r);
		if (err_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* test/fsab_mem_model.sv */
// ====================
// bus-side memory for the cache testbench, 4 KB of 64-bit words
// returns delayed eight-beat reads, applies masked writes, hands back credits
// ====================
`timescale 1ns/1ps

module fsab_mem_model #(
	parameter logic [31:0] SEED  = 32'he7bfefe7,
	parameter int          DELAY = 3
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  dcache_pkg::fsab_req_t req,
	input  logic                  hold, // withhold credit returns
	output logic                  credit,
	output dcache_pkg::fsab_rsp_t rsp,
	output int unsigned           read_count
);
	import dcache_pkg::*;

	localparam int WORDS = 512;

	logic [63:0] mem [WORDS];
	logic [3:0]  credit_pipe; // return delay per request
	int unsigned owed;
	int          rd_wait;
	int          rd_left;
	logic [8:0]  rd_ptr;
	logic [3:0]  rd_did;
	logic [3:0]  rd_subdid;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// pseudo random contents, mixed with the byte address of each word
	initial begin : init_mem
		logic [31:0] s;
		logic [31:0] a;
		logic [31:0] hi;
		s = SEED;
		for (int i = 0; i < WORDS; i++) begin
			a  = 32'(i) << 3;
			s  = lcg_next(s);
			hi = s ^ a;
			s  = lcg_next(s);
			mem[i] = {hi, s ^ a};
		end
	end

	// ====================
	// credits
	// ====================
	assign credit = (owed != 0) && !hold;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credit_pipe <= '0;
			owed        <= 0;
		end else begin
			credit_pipe <= {credit_pipe[2:0], req.valid};
			owed        <= owed + 32'(credit_pipe[3]) - 32'(credit);
		end
	end

	// ====================
	// read returns
	// ====================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp        <= '0;
			read_count <= 0;
			rd_wait    <= 0;
			rd_left    <= 0;
			rd_ptr     <= '0;
			rd_did     <= '0;
			rd_subdid  <= '0;
		end else begin
			rsp <= '0;
			if (req.valid && req.mode == FSAB_READ) begin
				read_count <= read_count + 1;
				rd_ptr     <= req.addr[11:3];
				rd_did     <= req.did; // beats go back to the requester
				rd_subdid  <= req.subdid;
				rd_wait    <= DELAY;
				rd_left    <= int'(req.len);
			end else if (rd_wait != 0) begin
				rd_wait <= rd_wait - 1;
			end else if (rd_left != 0) begin
				rsp.valid  <= 1'b1;
				rsp.did    <= rd_did;
				rsp.subdid <= rd_subdid;
				rsp.data   <= mem[rd_ptr];
				rd_ptr     <= rd_ptr + 9'd1;
				rd_left    <= rd_left - 1;
			end
		end
	end

	// masked write, one byte lane per mask bit
	always @(posedge clk) begin
		if (req.valid && req.mode == FSAB_WRITE) begin
			for (int b = 0; b < 8; b++) begin
				if (req.mask[b])
					mem[req.addr[11:3]][8*b +: 8] <= req.data[8*b +: 8];
			end
		end
	end

endmodule

/* test/clock_gen.sv */
// ====================
// testbench clock and reset, 10 ns period, reset low for a few cycles
// ====================
`timescale 1ns/1ps

module clock_gen #(
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// release away from the rising edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

/* hdl/dcache_top.sv */
// ====================
// data cache top, core port on one side and the bus on the other
// ====================
`timescale 1ns/1ps

module dcache_top (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [31:0]           addr,
	input  logic                  rd_req,
	input  logic                  wr_req,
	input  dcache_pkg::word_t     wr_data,
	output logic                  rw_wait,
	output dcache_pkg::word_t     rd_data,
	output dcache_pkg::fsab_req_t fsab_req,
	input  logic                  fsab_credit,
	input  dcache_pkg::fsab_rsp_t fsab_rsp
);
	import dcache_pkg::*;

	logic        hit;
	line_idx_t   idx;
	tag_t        tag;
	beat_idx_t   beat;
	logic        wr_hit;
	logic        fill_start;
	logic [31:0] fill_addr;
	logic        fill_pending;
	fill_beat_t  fill;

	dcache_lookup i_dcache_lookup (
		.clk, .arst_n, .addr, .fill, .fill_pending,
		.hit, .idx, .tag, .beat
	);

	dcache_data i_dcache_data (
		.clk, .idx, .beat,
		.addr_hi (addr[2]),
		.wr_hit, .wr_data, .fill, .rd_data
	);

	fsab_request i_fsab_request (
		.clk, .arst_n, .addr, .rd_req, .wr_req, .wr_data,
		.hit, .idx, .tag, .beat, .fill_pending,
		.credit (fsab_credit),
		.rw_wait,
		.req    (fsab_req),
		.fill_start, .fill_addr, .wr_hit
	);

	fill_tracker i_fill_tracker (
		.clk, .arst_n, .fill_start, .fill_addr,
		.rsp (fsab_rsp),
		.fill, .fill_pending
	);

endmodule

/* hdl/fill_tracker.sv */
// ====================
// stage 3, takes this cache's response beats and counts out a line fill
// ====================
`timescale 1ns/1ps
`include "dcache_config.svh"

module fill_tracker (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   fill_start,
	input  logic [31:0]            fill_addr,
	input  dcache_pkg::fsab_rsp_t  rsp,
	output dcache_pkg::fill_beat_t fill,
	output logic                   fill_pending
);
	import dcache_pkg::*;

	fill_state_e state_q;
	beat_idx_t   pos_q;
	line_idx_t   line_q;
	logic        rsp_match;

	// only beats with our ids belong to the fill
	assign rsp_match = rsp.valid && (rsp.did == `FSAB_DID_CPU)
		&& (rsp.subdid == `FSAB_SUBDID_DCACHE);

	assign fill_pending = (state_q == FILL_BUSY);

	always_comb begin
		fill.strobe = rsp_match && fill_pending;
		fill.idx    = line_q;
		fill.pos    = pos_q;
		fill.data   = rsp.data;
		fill.last   = (pos_q == beat_idx_t'(`DCACHE_BEATS - 1));
	end

	// ====================
	// fill FSM
	// ====================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= FILL_IDLE;
			pos_q   <= '0;
		end else begin
			case (state_q)
				FILL_IDLE: if (fill_start) begin
					state_q <= FILL_BUSY;
					pos_q   <= '0;
				end
				FILL_BUSY: if (fill.strobe) begin
					pos_q <= pos_q + 1'b1;
					if (fill.last)
						state_q <= FILL_IDLE; // line complete
				end
				default: state_q <= FILL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fill_start)
			line_q <= fill_addr[$bits(beat_idx_t) + 3 +: $bits(line_idx_t)];
	end

	a_no_stray_beat: assert property (
		@(posedge clk) disable iff (!arst_n) rsp_match |-> state_q == FILL_BUSY
	) else $error("response beat for the cache with no fill pending");

endmodule

/* hdl/fsab_request.sv */
// ====================
// second pipeline stage that counts credits, stalls the core and issues bus requests
// sends an 8-beat line read on a miss or a single masked write beat
// ====================
`timescale 1ns/1ps
`include "dcache_config.svh"

module fsab_request (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [31:0]           addr,
	input  logic                  rd_req,
	input  logic                  wr_req,
	input  dcache_pkg::word_t     wr_data,
	input  logic                  hit,
	input  dcache_pkg::line_idx_t idx,
	input  dcache_pkg::tag_t      tag,
	input  dcache_pkg::beat_idx_t beat,
	input  logic                  fill_pending,
	input  logic                  credit,
	output logic                  rw_wait,
	output dcache_pkg::fsab_req_t req,
	output logic                  fill_start,
	output logic [31:0]           fill_addr,
	output logic                  wr_hit
);
	import dcache_pkg::*;

	logic [`FSAB_CREDITS_W-1:0] credits_q;
	logic                       credit_avail;
	logic                       wr_issue;

	assign credit_avail = (credits_q != '0);

	// ====================
	// stall and issue decision
	// ====================
	assign rw_wait    = (rd_req && !hit) || (wr_req && !credit_avail);
	assign fill_start = rd_req && !hit && !fill_pending && credit_avail;
	assign wr_issue   = wr_req && credit_avail;
	assign wr_hit     = wr_issue && hit; // write-through also updates the cached half

	assign fill_addr = {tag, idx, 6'b0}; // line aligned

	always_comb begin
		req = '0;
		if (fill_start) begin
			req.valid  = 1'b1;
			req.mode   = FSAB_READ;
			req.did    = `FSAB_DID_CPU;
			req.subdid = `FSAB_SUBDID_DCACHE;
			req.addr   = fill_addr;
			req.len    = `FSAB_LEN_W'(`DCACHE_BEATS);
		end else if (wr_issue) begin
			req.valid  = 1'b1;
			req.mode   = FSAB_WRITE;
			req.did    = `FSAB_DID_CPU;
			req.subdid = `FSAB_SUBDID_DCACHE;
			req.addr   = {tag, idx, beat, 3'b000};
			req.len    = `FSAB_LEN_W'(1);
			req.data   = {wr_data, wr_data}; // mask picks the half
			req.mask   = addr[2] ? 8'hF0 : 8'h0F;
		end
	end

	// ====================
	// one credit out per request and one back per credit pulse
	// ====================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			credits_q <= `FSAB_CREDITS_W'(`FSAB_INITIAL_CREDITS);
		else
			credits_q <= credits_q + `FSAB_CREDITS_W'(credit) - `FSAB_CREDITS_W'(req.valid);
	end

	// an empty count only stays empty or takes one credit back
	a_no_credit_underflow: assert property (
		@(posedge clk) disable iff (!arst_n)
		credits_q == '0 |=> credits_q <= `FSAB_CREDITS_W'(1)
	) else $error("credit count taken below zero");

	// the bus never hands back more than it was given
	a_no_credit_overflow: assert property (
		@(posedge clk) disable iff (!arst_n)
		credits_q <= `FSAB_CREDITS_W'(`FSAB_INITIAL_CREDITS)
	) else $error("credit count above initial value");

endmodule

/* hdl/dcache_data.sv */
// ====================
// line storage as high and low word arrays
// read by line and beat, written by fill beats and by write hits
// ====================
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_data (
	input  logic                   clk,
	input  dcache_pkg::line_idx_t  idx,
	input  dcache_pkg::beat_idx_t  beat,
	input  logic                   addr_hi,
	input  logic                   wr_hit,
	input  dcache_pkg::word_t      wr_data,
	input  dcache_pkg::fill_beat_t fill,
	output dcache_pkg::word_t      rd_data
);
	import dcache_pkg::*;

	localparam int PTR_W = $bits(line_idx_t) + $bits(beat_idx_t);

	word_t             data_hi [`DCACHE_LINES * `DCACHE_BEATS];
	word_t             data_lo [`DCACHE_LINES * `DCACHE_BEATS];
	logic [PTR_W-1:0]  core_ptr;
	logic [PTR_W-1:0]  fill_ptr;

	assign core_ptr = {idx, beat};
	assign fill_ptr = {fill.idx, fill.pos};

	// address bit 2 picks the half
	assign rd_data = addr_hi ? data_hi[core_ptr] : data_lo[core_ptr];

	always_ff @(posedge clk) begin
		if (fill.strobe) begin
			data_hi[fill_ptr] <= fill.data[$bits(word_t) +: $bits(word_t)];
			data_lo[fill_ptr] <= fill.data[0 +: $bits(word_t)];
		end else if (wr_hit) begin
			if (addr_hi)
				data_hi[core_ptr] <= wr_data;
			else
				data_lo[core_ptr] <= wr_data;
		end
	end

	// ====================
	// checks
	// ====================

	// fills only run while the core is stalled on a read miss, so a write
	// hit from the request stage can never meet a fill beat
	a_no_fill_write_overlap: assert property (
		@(posedge clk) !(fill.strobe && wr_hit)
	) else $error("fill beat and write hit in the same cycle");

endmodule

/* hdl/dcache_lookup.sv */
// ====================
// stage 1, valid bits and tags, splits the core address and flags a hit
// ====================
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_lookup (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic [31:0]            addr,
	input  dcache_pkg::fill_beat_t fill,
	input  logic                   fill_pending,
	output logic                   hit,
	output dcache_pkg::line_idx_t  idx,
	output dcache_pkg::tag_t       tag,
	output dcache_pkg::beat_idx_t  beat
);
	import dcache_pkg::*;

	logic [`DCACHE_LINES-1:0] valid_q;
	tag_t                     tags_q [`DCACHE_LINES];
	tag_t                     fill_tag_q; // tag of the line being filled

	// ====================
	// address split
	// ====================
	assign beat = addr[3 +: $bits(beat_idx_t)];
	assign idx  = addr[$bits(beat_idx_t) + 3 +: $bits(line_idx_t)];
	assign tag  = addr[31 -: $bits(tag_t)];

	assign hit = valid_q[idx] && (tags_q[idx] == tag);

	// ====================
	// valid bits
	// ====================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
		end else if (fill.strobe) begin
			// invalid while beats land, valid again with the last one
			valid_q[fill.idx] <= fill.last;
		end
	end

	// the core holds its address through the miss, so the tag seen in
	// the cycle the fill starts is the one to keep
	always_ff @(posedge clk) begin
		if (!fill_pending)
			fill_tag_q <= tag;
		if (fill.strobe && fill.last)
			tags_q[fill.idx] <= fill_tag_q;
	end

endmodule

/* hdl/dcache_pkg.sv */
// ====================
// shared types for the data cache, address fields and bus records
// ====================
`include "dcache_config.svh"

package dcache_pkg;

	// address split is tag / line index / beat / byte in beat
	typedef logic [31-$clog2(`DCACHE_LINES)-$clog2(`DCACHE_BEATS)-3:0] tag_t;
	typedef logic [$clog2(`DCACHE_LINES)-1:0] line_idx_t;
	typedef logic [$clog2(`DCACHE_BEATS)-1:0] beat_idx_t;
	typedef logic [31:0] word_t;
	typedef logic [`FSAB_DATA_W-1:0] beat_t;

	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_e;

	typedef enum logic {
		FILL_IDLE,
		FILL_BUSY
	} fill_state_e;

	typedef struct packed {
		logic                   valid;
		fsab_mode_e             mode;
		logic [`FSAB_DID_W-1:0] did;
		logic [`FSAB_DID_W-1:0] subdid;
		logic [31:0]            addr;
		logic [`FSAB_LEN_W-1:0] len;
		beat_t                  data;
		logic [7:0]             mask; // one bit per byte lane
	} fsab_req_t;

	typedef struct packed {
		logic                   valid;
		logic [`FSAB_DID_W-1:0] did;
		logic [`FSAB_DID_W-1:0] subdid;
		beat_t                  data;
	} fsab_rsp_t;

	typedef struct packed {
		logic      strobe;
		line_idx_t idx;
		beat_idx_t pos;
		beat_t     data;
		logic      last; // eighth beat of the line
	} fill_beat_t;

endpackage

/* hdl/dcache_config.svh */
// ====================
// cache geometry and bus constants for the data cache
// included by the package and by every module that needs a size or an id
// ====================
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// 16 lines of eight 64-bit beats
`define DCACHE_LINES 16
`define DCACHE_BEATS 8

// bus widths
`define FSAB_DATA_W 64
`define FSAB_LEN_W 4
`define FSAB_DID_W 4

// credit counter, full credit after reset
`define FSAB_CREDITS_W 4
`define FSAB_INITIAL_CREDITS 8

// source ids that mark this cache's traffic
`define FSAB_DID_CPU 4'h0
`define FSAB_SUBDID_DCACHE 4'h1

`endif
